// ==== UsiPkg.sv ====
package UsiPkg;

	// --------------------------------------------------
	// Register bus geometry
	// --------------------------------------------------
	// Data and address share one width
	localparam int pUsiBusWidth    = 32;
	// Set for a write, clear for a read
	localparam int pUsiWrBit       = 30;
	// Block field sits right above the offset field
	localparam int pBlockAdrsWidth = 8;
	localparam int pCsrAdrsWidth   = 16;
	// Only the low offset bits are decoded
	localparam int pCsrActiveWidth = 8;

	// Block map
	localparam int pBlockCount    = 2;
	localparam int pBlockIdxWidth = $clog2(pBlockCount);
	localparam logic [pBlockAdrsWidth-1:0] pBlockMap0 = 8'h06;
	localparam logic [pBlockAdrsWidth-1:0] pBlockMap1 = 8'h07;

	// CSR offsets inside one block
	localparam logic [pCsrActiveWidth-1:0] pCsrRamWd   = 8'h00;
	localparam logic [pCsrActiveWidth-1:0] pCsrRamAdrs = 8'h04;
	localparam logic [pCsrActiveWidth-1:0] pCsrRamEn   = 8'h08;
	localparam logic [pCsrActiveWidth-1:0] pCsrStatus  = 8'h40;
	localparam logic [pCsrActiveWidth-1:0] pCsrRamRd   = 8'h44;
	localparam logic [pCsrActiveWidth-1:0] pCsrRamRdVd = 8'h48;

endpackage

// ==== UfiPkg.sv ====
package UfiPkg;

	// --------------------------------------------------
	// Memory side geometry
	// --------------------------------------------------
	// RAM word width
	localparam int pUfiDqBusWidth   = 16;
	// Full width of the software address register
	localparam int pUfiAdrsBusWidth = 32;

	// 64 words, only the low address bits reach the array
	localparam int pRamDepthLog2 = 6;
	localparam int pRamDepth     = 2 ** pRamDepthLog2;

	// --------------------------------------------------
	// Arbiter ports
	// --------------------------------------------------
	// One port per CSR block
	localparam int pReqCount    = UsiPkg::pBlockCount;
	localparam int pReqIdxWidth = $clog2(pReqCount);

endpackage

// ==== UfiReqIf.sv ====
interface UfiReqIf;

	// Request side, driven by the CSR block
	// Level, held until ack
	logic req;
	// 1 for write, 0 for read
	logic we;
	logic [UfiPkg::pUfiAdrsBusWidth-1:0] adrs;
	logic [UfiPkg::pUfiDqBusWidth-1:0] wd;

	// Response side, driven by the arbiter
	// One-cycle pulse, request taken into the slot
	logic ack;
	// Slot holds an ungranted request
	logic full;
	// Nothing pending and no read in flight
	logic emp;
	logic [UfiPkg::pUfiDqBusWidth-1:0] rd;
	// One-cycle pulse with the read word
	logic rdVd;

	modport csr
	(
		output req, we, adrs, wd,
		input ack, full, emp, rd, rdVd
	);

	modport arb
	(
		input req, we, adrs, wd,
		output ack, full, emp, rd, rdVd
	);

endinterface

// ==== UfiMemIf.sv ====
interface UfiMemIf;

	// Access strobe, one cycle per word
	logic en;
	logic we;
	// Full address, the RAM keeps only the low bits
	logic [UfiPkg::pUfiAdrsBusWidth-1:0] adrs;
	logic [UfiPkg::pUfiDqBusWidth-1:0] wd;

	// Read word and its pulse, one cycle after the strobe
	logic [UfiPkg::pUfiDqBusWidth-1:0] rd;
	logic rdVd;

	modport arb
	(
		output en, we, adrs, wd,
		input rd, rdVd
	);

	modport mem
	(
		input en, we, adrs, wd,
		output rd, rdVd
	);

endinterface

// ==== UsiBusDecoder.sv ====
module UsiBusDecoder
(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic [UsiPkg::pUsiBusWidth-1:0] UsiAdrs,
	input  logic [UsiPkg::pBlockCount-1:0][UsiPkg::pUsiBusWidth-1:0] CsrRd,
	output logic [UsiPkg::pBlockCount-1:0] Sel,
	output logic [UsiPkg::pUsiBusWidth-1:0] UsiRd
);

	// Block field right above the offset
	logic [UsiPkg::pBlockAdrsWidth-1:0] wBlock;
	logic [UsiPkg::pBlockIdxWidth-1:0] wSelIdx;
	logic [UsiPkg::pBlockIdxWidth-1:0] rSelIdx;
	logic rSelVd;

	assign wBlock = UsiAdrs[UsiPkg::pCsrAdrsWidth +: UsiPkg::pBlockAdrsWidth];

	// One select per mapped block
	assign Sel[0] = (wBlock == UsiPkg::pBlockMap0);
	assign Sel[1] = (wBlock == UsiPkg::pBlockMap1);

	// Encode the hit into an index
	always_comb
	begin
		wSelIdx = '0;
		for (int i = 0; i < UsiPkg::pBlockCount; i++)
			if (Sel[i])
				wSelIdx = (UsiPkg::pBlockIdxWidth)'(i);
	end

	// Index registered in step with the CSR read data
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rSelVd <= 1'b0;
		else
			rSelVd <= |Sel;
		rSelIdx <= wSelIdx;
	end

	// Unmapped block reads as zero
	assign UsiRd = rSelVd ? CsrRd[rSelIdx] : '0;

	// Block map entries must stay distinct
	assert property (@(posedge iSCLK) disable iff (iSRST) $onehot0(Sel));

endmodule

// ==== MicroControllerCsr.sv ====
module MicroControllerCsr #(
	parameter logic [UsiPkg::pBlockAdrsWidth-1:0] pBlockMap = 8'h06
)(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic Sel,
	input  logic [UsiPkg::pUsiBusWidth-1:0] UsiWd,
	input  logic [UsiPkg::pUsiBusWidth-1:0] UsiAdrs,
	output logic [UsiPkg::pUsiBusWidth-1:0] CsrRd,
	UfiReqIf.csr Ufi
);

	// --------------------------------------------------
	// Write decode
	// --------------------------------------------------
	logic [UsiPkg::pCsrActiveWidth-1:0] wOfs;
	logic wWr;
	logic wWrRamWd;
	logic wWrRamAdrs;
	logic wWrRamEn;
	logic wWrRamRdVd;
	// New command only with no request pending or in flight
	logic wIdle;
	logic wCmd;

	// Register file
	logic [UfiPkg::pUfiDqBusWidth-1:0] rRamWd;
	logic [UfiPkg::pUfiAdrsBusWidth-1:0] rRamAdrs;
	logic rRamEn;
	logic rReq;
	logic rFull;
	logic rEmp;
	logic [UfiPkg::pUfiDqBusWidth-1:0] rRamRd;
	logic rRamRdVd;

	assign wOfs = UsiAdrs[UsiPkg::pCsrActiveWidth-1:0];
	assign wWr  = Sel & UsiAdrs[UsiPkg::pUsiWrBit];

	assign wWrRamWd   = wWr & (wOfs == UsiPkg::pCsrRamWd);
	assign wWrRamAdrs = wWr & (wOfs == UsiPkg::pCsrRamAdrs);
	assign wWrRamEn   = wWr & (wOfs == UsiPkg::pCsrRamEn);
	assign wWrRamRdVd = wWr & (wOfs == UsiPkg::pCsrRamRdVd);

	assign wIdle = ~rReq & Ufi.emp;
	// Enable write while busy is dropped
	assign wCmd  = wWrRamEn & wIdle;

	// --------------------------------------------------
	// Register update
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rRamWd   <= '0;
			rRamAdrs <= '0;
			rRamEn   <= 1'b0;
			rReq     <= 1'b0;
			rFull    <= 1'b0;
			rEmp     <= 1'b1;
			rRamRd   <= '0;
			rRamRdVd <= 1'b0;
		end
		else
		begin
			// Data registers latch even while busy
			if (wWrRamWd)
				rRamWd <= UsiWd[UfiPkg::pUfiDqBusWidth-1:0];
			if (wWrRamAdrs)
				rRamAdrs <= UsiWd[UfiPkg::pUfiAdrsBusWidth-1:0];
			if (wCmd)
				rRamEn <= UsiWd[0];
			// Request drops with ack
			if (Ufi.ack)
				rReq <= 1'b0;
			else if (wCmd)
				rReq <= 1'b1;
			// Status snapshot
			rFull <= Ufi.full;
			rEmp  <= Ufi.emp;
			// Keep our own word, the RAM output is shared
			if (Ufi.rdVd)
				rRamRd <= Ufi.rd;
			// Sticky flag, a new word beats the clear
			if (Ufi.rdVd)
				rRamRdVd <= 1'b1;
			else if (wWrRamRdVd)
				rRamRdVd <= 1'b0;
		end
	end

	assign Ufi.req  = rReq;
	assign Ufi.we   = rRamEn;
	assign Ufi.adrs = rRamAdrs;
	assign Ufi.wd   = rRamWd;

	// --------------------------------------------------
	// Read path
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		case (wOfs)
			UsiPkg::pCsrRamWd:   CsrRd <= (UsiPkg::pUsiBusWidth)'(rRamWd);
			UsiPkg::pCsrRamAdrs: CsrRd <= (UsiPkg::pUsiBusWidth)'(rRamAdrs);
			UsiPkg::pCsrRamEn:   CsrRd <= (UsiPkg::pUsiBusWidth)'(rRamEn);
			// Empty at bit 4, full at bit 0
			UsiPkg::pCsrStatus:  CsrRd <= (UsiPkg::pUsiBusWidth)'({3'b000, rEmp, 3'b000, rFull});
			UsiPkg::pCsrRamRd:   CsrRd <= (UsiPkg::pUsiBusWidth)'(rRamRd);
			UsiPkg::pCsrRamRdVd: CsrRd <= (UsiPkg::pUsiBusWidth)'(rRamRdVd);
			default:             CsrRd <= '0;
		endcase
	end

	// Request is only withdrawn by the arbiter
	assert property (@(posedge iSCLK) disable iff (iSRST) $fell(rReq) |-> $past(Ufi.ack));

	// Decoder select agrees with this block's map entry
	assert property (@(posedge iSCLK) disable iff (iSRST)
		Sel |-> (UsiAdrs[UsiPkg::pCsrAdrsWidth +: UsiPkg::pBlockAdrsWidth] == pBlockMap));

endmodule

// ==== UfiArbiter.sv ====
module UfiArbiter
(
	input  logic iSCLK,
	input  logic iSRST,
	UfiReqIf.arb Req [UfiPkg::pReqCount],
	UfiMemIf.arb Mem
);

	// Port signals gathered into vectors
	logic [UfiPkg::pReqCount-1:0] wReq;
	logic [UfiPkg::pReqCount-1:0] wWe;
	logic [UfiPkg::pReqCount-1:0][UfiPkg::pUfiAdrsBusWidth-1:0] wAdrs;
	logic [UfiPkg::pReqCount-1:0][UfiPkg::pUfiDqBusWidth-1:0] wWd;
	logic [UfiPkg::pReqCount-1:0] wRdHit;
	logic [UfiPkg::pReqCount-1:0] wAccept;

	// One slot per port
	logic [UfiPkg::pReqCount-1:0] rSlotVd;
	logic [UfiPkg::pReqCount-1:0] rSlotWe;
	logic [UfiPkg::pReqCount-1:0][UfiPkg::pUfiAdrsBusWidth-1:0] rSlotAdrs;
	logic [UfiPkg::pReqCount-1:0][UfiPkg::pUfiDqBusWidth-1:0] rSlotWd;
	logic [UfiPkg::pReqCount-1:0] rAck;
	// Read granted with data not yet back
	logic [UfiPkg::pReqCount-1:0] rOut;

	// Grant and RAM command stage
	logic [UfiPkg::pReqCount-1:0] wGrant;
	logic [UfiPkg::pReqIdxWidth-1:0] wGntIdx;
	logic wGntVd;
	logic [UfiPkg::pReqIdxWidth-1:0] rLast;
	logic rMemEn;
	logic rMemWe;
	logic [UfiPkg::pUfiAdrsBusWidth-1:0] rMemAdrs;
	logic [UfiPkg::pUfiDqBusWidth-1:0] rMemWd;
	// Owner of the strobe and then of the returning word
	logic [UfiPkg::pReqIdxWidth-1:0] rOwner;
	logic [UfiPkg::pReqIdxWidth-1:0] rRdOwner;

	// --------------------------------------------------
	// Port wiring
	// --------------------------------------------------
	for (genvar i = 0; i < UfiPkg::pReqCount; i++)
	begin : gPort
		assign wReq[i]  = Req[i].req;
		assign wWe[i]   = Req[i].we;
		assign wAdrs[i] = Req[i].adrs;
		assign wWd[i]   = Req[i].wd;
		assign wRdHit[i] = Mem.rdVd & (rRdOwner == (UfiPkg::pReqIdxWidth)'(i));
		assign Req[i].ack  = rAck[i];
		assign Req[i].full = rSlotVd[i];
		assign Req[i].emp  = ~rSlotVd[i] & ~rOut[i];
		assign Req[i].rd   = Mem.rd;
		assign Req[i].rdVd = wRdHit[i];
	end

	assign wAccept = wReq & ~rSlotVd & ~rOut;

	// Round-robin search starting after the last winner
	always_comb
	begin
		int k;
		wGrant  = '0;
		wGntIdx = '0;
		wGntVd  = 1'b0;
		for (int off = 1; off <= UfiPkg::pReqCount; off++)
		begin
			k = int'(rLast) + off;
			if (k >= UfiPkg::pReqCount)
				k = k - UfiPkg::pReqCount;
			if (!wGntVd && rSlotVd[k])
			begin
				wGntVd    = 1'b1;
				wGntIdx   = (UfiPkg::pReqIdxWidth)'(k);
				wGrant[k] = 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Control state
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rSlotVd <= '0;
			rAck    <= '0;
			rOut    <= '0;
			rMemEn  <= 1'b0;
			rLast   <= '0;
		end
		else
		begin
			rAck   <= wAccept;
			rMemEn <= wGntVd;
			if (wGntVd)
				rLast <= wGntIdx;
			for (int i = 0; i < UfiPkg::pReqCount; i++)
			begin
				if (wAccept[i])
					rSlotVd[i] <= 1'b1;
				else if (wGrant[i])
					rSlotVd[i] <= 1'b0;
				if (wGrant[i] && !rSlotWe[i])
					rOut[i] <= 1'b1;
				else if (wRdHit[i])
					rOut[i] <= 1'b0;
			end
		end
	end

	// Slot payload and RAM command
	always_ff @(posedge iSCLK)
	begin
		for (int i = 0; i < UfiPkg::pReqCount; i++)
			if (wAccept[i])
			begin
				rSlotWe[i]   <= wWe[i];
				rSlotAdrs[i] <= wAdrs[i];
				rSlotWd[i]   <= wWd[i];
			end
		if (wGntVd)
		begin
			rMemWe   <= rSlotWe[wGntIdx];
			rMemAdrs <= rSlotAdrs[wGntIdx];
			rMemWd   <= rSlotWd[wGntIdx];
			rOwner   <= wGntIdx;
		end
		// RAM takes the read at this edge
		if (rMemEn && !rMemWe)
			rRdOwner <= rOwner;
	end

	assign Mem.en   = rMemEn;
	assign Mem.we   = rMemWe;
	assign Mem.adrs = rMemAdrs;
	assign Mem.wd   = rMemWd;

	// At most one winner per cycle
	assert property (@(posedge iSCLK) disable iff (iSRST) $onehot0(wGrant));

endmodule

// ==== UfiRam.sv ====
module UfiRam
(
	input  logic iSCLK,
	UfiMemIf.mem Mem
);

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	logic [UfiPkg::pUfiDqBusWidth-1:0] rMem [UfiPkg::pRamDepth];
	logic [UfiPkg::pRamDepthLog2-1:0] wIdx;
	logic [UfiPkg::pUfiDqBusWidth-1:0] rRd;
	logic rRdVd;

	// Upper address bits are ignored
	assign wIdx = Mem.adrs[UfiPkg::pRamDepthLog2-1:0];

	// Single port, write or read per strobe
	always_ff @(posedge iSCLK)
	begin
		if (Mem.en && Mem.we)
			rMem[wIdx] <= Mem.wd;
		if (Mem.en && !Mem.we)
			rRd <= rMem[wIdx];
		// Pulse one cycle after a read strobe
		rRdVd <= Mem.en & ~Mem.we;
	end

	assign Mem.rd   = rRd;
	assign Mem.rdVd = rRdVd;

	// Address from the CSR register must be settled when strobed
	assert property (@(posedge iSCLK) Mem.en |-> !$isunknown(Mem.adrs));

endmodule

// ==== UfiRamSubsystem.sv ====
module UfiRamSubsystem
(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic [UsiPkg::pUsiBusWidth-1:0] UsiWd,
	input  logic [UsiPkg::pUsiBusWidth-1:0] UsiAdrs,
	output logic [UsiPkg::pUsiBusWidth-1:0] UsiRd
);

	// --------------------------------------------------
	// Register bus side
	// --------------------------------------------------
	logic [UsiPkg::pBlockCount-1:0] wSel;
	logic [UsiPkg::pBlockCount-1:0][UsiPkg::pUsiBusWidth-1:0] wCsrRd;

	// One request link per CSR block
	UfiReqIf reqIf [UfiPkg::pReqCount] ();
	UfiMemIf memIf ();

	UsiBusDecoder decoder_i
	(
		.iSCLK(iSCLK), .iSRST(iSRST),
		.UsiAdrs(UsiAdrs), .CsrRd(wCsrRd),
		.Sel(wSel), .UsiRd(UsiRd)
	);

	// Blocks at 0x06 and 0x07
	MicroControllerCsr #(.pBlockMap(UsiPkg::pBlockMap0)) csr0_i
	(
		.iSCLK(iSCLK), .iSRST(iSRST), .Sel(wSel[0]),
		.UsiWd(UsiWd), .UsiAdrs(UsiAdrs),
		.CsrRd(wCsrRd[0]), .Ufi(reqIf[0])
	);

	MicroControllerCsr #(.pBlockMap(UsiPkg::pBlockMap1)) csr1_i
	(
		.iSCLK(iSCLK), .iSRST(iSRST), .Sel(wSel[1]),
		.UsiWd(UsiWd), .UsiAdrs(UsiAdrs),
		.CsrRd(wCsrRd[1]), .Ufi(reqIf[1])
	);

	// --------------------------------------------------
	// Memory side
	// --------------------------------------------------
	UfiArbiter arbiter_i (.iSCLK(iSCLK), .iSRST(iSRST), .Req(reqIf), .Mem(memIf));

	UfiRam ram_i (.iSCLK(iSCLK), .Mem(memIf));

endmodule

// ==== tb_UfiRamSubsystem.sv ====
module tb_UfiRamSubsystem;

	timeunit 1ns;
	timeprecision 1ps;

	logic iSCLK;
	logic iSRST;
	logic [31:0] UsiWd;
	logic [31:0] UsiAdrs;
	logic [31:0] UsiRd;

	// One entry per case line
	logic [31:0] caseOp [$];
	logic [31:0] caseAdrs [$];
	logic [31:0] caseData [$];
	logic [31:0] caseExp [$];

	int errorCount = 0;
	int passCount = 0;
	int cycleCount = 0;
	// Zero until the cases are loaded
	int cycleLimit = 0;

	UfiRamSubsystem dut_i
	(
		.iSCLK(iSCLK), .iSRST(iSRST),
		.UsiWd(UsiWd), .UsiAdrs(UsiAdrs), .UsiRd(UsiRd)
	);

	// --------------------------------------------------
	// Clock and run limit
	// --------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #5 iSCLK = ~iSCLK;
	end

	always @(posedge iSCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("Run stopped after %0d cycles, the cases did not finish", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// Bus helpers
	// --------------------------------------------------
	// Lines that do not hold four hex fields are comments
	task automatic loadCases();
		int fd;
		int n;
		string line;
		logic [31:0] opV;
		logic [31:0] adrsV;
		logic [31:0] dataV;
		logic [31:0] expV;
		fd = $fopen("ufi_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open ufi_cases.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			n = $sscanf(line, "%h %h %h %h", opV, adrsV, dataV, expV);
			if (n == 4)
			begin
				caseOp.push_back(opV);
				caseAdrs.push_back(adrsV);
				caseData.push_back(dataV);
				caseExp.push_back(expV);
			end
		end
		$fclose(fd);
		if (caseOp.size() == 0)
		begin
			$display("The cases file holds no cases");
			errorCount++;
		end
	endtask

	// Held for one cycle until the next operation
	task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
		@(posedge iSCLK);
		UsiAdrs <= adrs;
		UsiWd   <= data;
	endtask

	// Data shows one cycle after the address
	task automatic busRead(input logic [31:0] adrs, output logic [31:0] data);
		@(posedge iSCLK);
		UsiAdrs <= adrs;
		@(posedge iSCLK);
		UsiAdrs <= '0;
		@(negedge iSCLK);
		data = UsiRd;
	endtask

	// Address 0 hits no block
	task automatic idleGap(input int cycles);
		repeat (cycles)
		begin
			@(posedge iSCLK);
			UsiAdrs <= '0;
			UsiWd   <= '0;
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal)
		begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
			errorCount++;
		end
	endtask

	// --------------------------------------------------
	// Case replay
	// --------------------------------------------------
	initial
	begin
		int errBefore;
		int polls;
		logic [31:0] rdVal;
		iSRST   = 1'b1;
		UsiAdrs = '0;
		UsiWd   = '0;
		void'($urandom(38812));
		loadCases();
		cycleLimit = 40 * caseOp.size() + 100;
		repeat (4) @(posedge iSCLK);
		iSRST <= 1'b0;
		for (int i = 0; i < caseOp.size(); i++)
		begin
			errBefore = errorCount;
			case (caseOp[i])
				0: busWrite(caseAdrs[i], caseData[i]);
				1:
				begin
					// At least two idle cycles since status lags by two
					idleGap(2 + $urandom % 3);
					busRead(caseAdrs[i], rdVal);
					checkValue("UsiRd", caseExp[i], rdVal);
				end
				2:
				begin
					polls = 0;
					rdVal = ~caseExp[i];
					while (rdVal !== caseExp[i] && polls < 50)
					begin
						idleGap(2 + $urandom % 3);
						busRead(caseAdrs[i], rdVal);
						polls++;
					end
					if (rdVal !== caseExp[i])
					begin
						$display("Address %h never read %h within 50 reads", caseAdrs[i], caseExp[i]);
						errorCount++;
					end
				end
				default:
				begin
					$display("Case %0d has an unknown operation %0h", i, caseOp[i]);
					errorCount++;
				end
			endcase
			if (errorCount == errBefore)
			begin
				passCount++;
				$display("case %0d op %0h adrs %h: ok", i, caseOp[i], caseAdrs[i]);
			end
			else
				$display("case %0d op %0h adrs %h: wrong", i, caseOp[i], caseAdrs[i]);
		end
		idleGap(1);
		$display("%0d cases, %0d ok, %0d errors", caseOp.size(), passCount, errorCount);
		if (errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== ufi_cases.txt ====
# op adrs data expect, all hex; op 0 = bus write, 1 = read and compare, 2 = poll until equal
# adrs bits 23:16 = block, bit 30 = write; data unused on reads, expect unused on writes
# status and read-valid after reset
1 00060040 0 00000010
1 00070040 0 00000010
1 00060048 0 00000000
1 00070048 0 00000000
# register readback with zero fill, unmapped offset and block
0 40060000 FFFF1234 0
1 00060000 0 00001234
0 40070004 0000ABCD 0
1 00070004 0 0000ABCD
1 0006000C 0 00000000
1 00050000 0 00000000
# write then read through block 0x06, flag cleared afterwards
0 40060000 00005A5A 0
0 40060004 00000005 0
0 40060008 00000001 0
2 00060040 0 00000010
0 40060008 00000000 0
2 00060048 0 00000001
1 00060044 0 00005A5A
0 40060048 00000000 0
1 00060048 0 00000000
# block 0x07 sees the same word, upper address bits ignored
0 40070004 00000045 0
0 40070008 00000000 0
2 00070048 0 00000001
1 00070044 0 00005A5A
0 40070048 00000000 0
# back to back writes, then back to back crossed reads
0 40060000 00001111 0
0 40060004 00000010 0
0 40070000 00002222 0
0 40070004 00000020 0
0 40060008 00000001 0
0 40070008 00000001 0
2 00060040 0 00000010
2 00070040 0 00000010
0 40060004 00000020 0
0 40070004 00000010 0
0 40060008 00000000 0
0 40070008 00000000 0
2 00060048 0 00000001
2 00070048 0 00000001
1 00060044 0 00002222
1 00070044 0 00001111
0 40060048 00000000 0
0 40070048 00000000 0
# second command while busy is dropped, RAM keeps the first word
0 40060000 00003333 0
0 40060004 00000030 0
0 40060008 00000001 0
0 40060000 00004444 0
0 40060008 00000001 0
2 00060040 0 00000010
0 40060008 00000000 0
2 00060048 0 00000001
1 00060044 0 00003333

// ==== filelist.f ====
UsiPkg.sv
UfiPkg.sv
UfiReqIf.sv
UfiMemIf.sv
UsiBusDecoder.sv
MicroControllerCsr.sv
UfiArbiter.sv
UfiRam.sv
UfiRamSubsystem.sv
tb_UfiRamSubsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_UfiRamSubsystem
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
